/* hdl/pss_cfg.svh */
`ifndef PSS_CFG_SVH
`define PSS_CFG_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------

// width of one signed I or Q input component
`define PSS_SAMPLE_DW 8

// number of taps in each PSS sequence, the half length is derived from it
`define PSS_LEN 16

// half-sum component width, with one spare bit so a full half of
// extreme samples cannot wrap
`define PSS_ACC_DW (`PSS_SAMPLE_DW + $clog2(`PSS_LEN) + 1)

// each offset product component is the sum of two full products
`define PSS_PROD_DW (2 * `PSS_ACC_DW + 1)

// ----------------------------------------------------------------------
// peak detection
// ----------------------------------------------------------------------

// number of past correlator outputs in the average, keep it a power of two
`define PSS_WINDOW_LEN 8

// a peak must exceed the window average times 2**PSS_PEAK_SHIFT
`define PSS_PEAK_SHIFT 2

`endif

/* hdl/pss_pkg.sv */
`include "pss_cfg.svh"

package pss_pkg;

    // one complex baseband sample
    typedef struct packed {
        logic signed [`PSS_SAMPLE_DW-1:0] re;
        logic signed [`PSS_SAMPLE_DW-1:0] im;
    } sample_t;

    // one half of a correlation sum
    typedef struct packed {
        logic signed [`PSS_ACC_DW-1:0] re;
        logic signed [`PSS_ACC_DW-1:0] im;
    } acc_t;

    // |re| + |im| of the full sum, which is one bit wider than a half-sum
    typedef logic [`PSS_ACC_DW+1:0] mag_t;

    typedef enum logic [1:0] {
        MODE_SEARCH = 2'd0,
        MODE_FIND   = 2'd1,
        MODE_PAUSE  = 2'd2
    } mode_t;

    // ------------------------------------------------------------------
    // tap sign patterns, one row per N_id_2
    // ------------------------------------------------------------------
    // entry k sits at bits [2k+1:2k]; bit 1 negates re and bit 0 negates im
    // entry 0 meets the oldest sample of the window
    localparam logic [2:0][`PSS_LEN-1:0][1:0] PSS_TAPS = {
        32'he61a_8f53,
        32'h4b27_d0e9,
        32'h9c5e_36a1
    };

endpackage

/* hdl/pss_correlator.sv */
`timescale 1ns/1ps
`include "pss_cfg.svh"

module pss_correlator import pss_pkg::*; #(
    parameter int unsigned N_ID = 0
) (
    input  logic    clk_i,
    input  logic    reset_ni,
    input  sample_t sample_i,
    input  logic    sample_valid_i,
    output mag_t    mag_o,
    output acc_t    c0_o,
    output acc_t    c1_o,
    output logic    valid_o
);

    localparam int HALF = `PSS_LEN / 2;

    // ------------------------------------------------------------------
    // sample window
    // ------------------------------------------------------------------
    // the stored history holds LEN-1 samples and the incoming sample
    // completes the window, so it lines up with the last tap
    sample_t dline_q [`PSS_LEN-1];
    sample_t win [`PSS_LEN];

    always_comb begin
        for (int k = 0; k < `PSS_LEN - 1; k++) begin
            win[k] = dline_q[k];
        end
        win[`PSS_LEN-1] = sample_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < `PSS_LEN - 1; k++) begin
                dline_q[k] <= '0;
            end
        end else if (sample_valid_i) begin
            for (int k = 0; k < `PSS_LEN - 1; k++) begin
                dline_q[k] <= win[k+1];
            end
        end
    end

    // ------------------------------------------------------------------
    // stage 1, half-sums of the window times the conjugate taps
    // ------------------------------------------------------------------
    acc_t h0;
    acc_t h1;
    acc_t s1_c0_q;
    acc_t s1_c1_q;
    logic s1_valid_q;

    // with taps of +-1 each product term is a signed add of re and im
    always_comb begin
        logic signed [`PSS_ACC_DW-1:0] a;
        logic signed [`PSS_ACC_DW-1:0] b;
        logic signed [`PSS_ACC_DW-1:0] term_re;
        logic signed [`PSS_ACC_DW-1:0] term_im;
        logic [1:0] tap;
        h0 = '0;
        h1 = '0;
        for (int k = 0; k < `PSS_LEN; k++) begin
            a = win[k].re;
            b = win[k].im;
            tap = PSS_TAPS[N_ID][k];
            term_re = (tap[1] ? -a : a) + (tap[0] ? -b : b);
            term_im = (tap[1] ? -b : b) - (tap[0] ? -a : a);
            if (k < HALF) begin
                h0.re = h0.re + term_re;
                h0.im = h0.im + term_im;
            end else begin
                h1.re = h1.re + term_re;
                h1.im = h1.im + term_im;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            s1_c0_q <= h0;
            s1_c1_q <= h1;
        end
    end

    // ------------------------------------------------------------------
    // stage 2, full sum magnitude
    // ------------------------------------------------------------------
    logic signed [`PSS_ACC_DW:0] full_re;
    logic signed [`PSS_ACC_DW:0] full_im;
    logic [`PSS_ACC_DW:0] abs_re;
    logic [`PSS_ACC_DW:0] abs_im;

    assign full_re = s1_c0_q.re + s1_c1_q.re;
    assign full_im = s1_c0_q.im + s1_c1_q.im;
    assign abs_re = full_re[`PSS_ACC_DW] ? -full_re : full_re;
    assign abs_im = full_im[`PSS_ACC_DW] ? -full_im : full_im;

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            c0_o <= s1_c0_q;
            c1_o <= s1_c1_q;
            mag_o <= abs_re + abs_im;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s1_valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            s1_valid_q <= sample_valid_i;
            valid_o <= s1_valid_q;
        end
    end

    // the result of every accepted sample leaves exactly two cycles later
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        sample_valid_i |-> ##2 valid_o);
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        valid_o |-> $past(sample_valid_i, 2));

endmodule

/* hdl/pss_peak_detector.sv */
`timescale 1ns/1ps
`include "pss_cfg.svh"

module pss_peak_detector import pss_pkg::*; (
    input  logic clk_i,
    input  logic reset_ni,
    input  mag_t mag_i,
    input  logic valid_i,
    output logic peak_o
);

    localparam int WIN_LOG = $clog2(`PSS_WINDOW_LEN);
    localparam int SUM_DW = $bits(mag_t) + WIN_LOG;
    localparam int THR_DW = SUM_DW + `PSS_PEAK_SHIFT;

    mag_t win_q [`PSS_WINDOW_LEN];
    logic [SUM_DW-1:0] sum_q;
    logic [WIN_LOG:0] fill_q;
    logic full;
    logic [THR_DW-1:0] thresh;

    assign full = (fill_q == `PSS_WINDOW_LEN);

    // window average scaled up by the peak factor
    assign thresh = THR_DW'(sum_q >> WIN_LOG) << `PSS_PEAK_SHIFT;

    // ------------------------------------------------------------------
    // history of past magnitudes, win_q[0] is the newest
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            win_q[0] <= mag_i;
            for (int k = 1; k < `PSS_WINDOW_LEN; k++) begin
                win_q[k] <= win_q[k-1];
            end
        end
    end

    // ------------------------------------------------------------------
    // running sum, fill level and the threshold test
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_q <= '0;
            fill_q <= '0;
            peak_o <= 1'b0;
        end else begin
            // the test uses the history before the new value joins it
            peak_o <= valid_i && full && (mag_i > thresh);
            if (valid_i) begin
                if (full) begin
                    // the oldest entry falls out as the new one enters
                    sum_q <= sum_q + SUM_DW'(mag_i)
                           - SUM_DW'(win_q[`PSS_WINDOW_LEN-1]);
                end else begin
                    sum_q <= sum_q + SUM_DW'(mag_i);
                    fill_q <= fill_q + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/pss_cfo_calc.sv */
`timescale 1ns/1ps
`include "pss_cfg.svh"

module pss_cfo_calc import pss_pkg::*; (
    input  logic                           clk_i,
    input  logic                           reset_ni,
    input  acc_t                           c0_i,
    input  acc_t                           c1_i,
    input  logic                           start_i,
    output logic signed [`PSS_PROD_DW-1:0] cfo_re_o,
    output logic signed [`PSS_PROD_DW-1:0] cfo_im_o,
    output logic                           done_o
);

    localparam int MUL_DW = 2 * `PSS_ACC_DW;

    // ------------------------------------------------------------------
    // stage 1, partial products of conj(c0) * c1
    // ------------------------------------------------------------------
    logic signed [MUL_DW-1:0] p_rr_q;
    logic signed [MUL_DW-1:0] p_ii_q;
    logic signed [MUL_DW-1:0] p_ri_q;
    logic signed [MUL_DW-1:0] p_ir_q;
    logic s1_valid_q;

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            p_rr_q <= c0_i.re * c1_i.re;
            p_ii_q <= c0_i.im * c1_i.im;
            p_ri_q <= c0_i.re * c1_i.im;
            p_ir_q <= c0_i.im * c1_i.re;
        end
    end

    // ------------------------------------------------------------------
    // stage 2, combine into the complex result
    // ------------------------------------------------------------------
    // the angle of this product is the phase step between the two halves
    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            cfo_re_o <= p_rr_q + p_ii_q;
            cfo_im_o <= p_ri_q - p_ir_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s1_valid_q <= 1'b0;
            done_o <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
            done_o <= s1_valid_q;
        end
    end

endmodule

/* hdl/pss_detector.sv */
`timescale 1ns/1ps
`include "pss_cfg.svh"

module pss_detector import pss_pkg::*; (
    input  logic                           clk_i,
    input  logic                           reset_ni,
    input  sample_t                        sample_i,
    input  logic                           sample_valid_i,
    input  mode_t                          mode_i,
    input  logic [1:0]                     requested_n_id_2_i,
    output logic [1:0]                     n_id_2_o,
    output logic                           n_id_2_valid_o,
    output logic signed [`PSS_PROD_DW-1:0] cfo_re_o,
    output logic signed [`PSS_PROD_DW-1:0] cfo_im_o,
    output logic                           cfo_valid_o
);

    typedef enum logic [1:0] {
        CFO_WAIT_PEAK,
        CFO_LAUNCH,
        CFO_WAIT_RESULT
    } cfo_state_t;

    logic corr_en_q;
    mag_t corr_mag [3];
    acc_t corr_c0 [3];
    acc_t corr_c1 [3];
    logic [2:0] corr_valid;
    logic [2:0] peak;

    // ------------------------------------------------------------------
    // one correlator and peak detector per N_id_2
    // ------------------------------------------------------------------
    for (genvar i = 0; i < 3; i++) begin : g_branch
        pss_correlator #(
            .N_ID(i)
        ) u_corr (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .sample_i(sample_i),
            .sample_valid_i(sample_valid_i && corr_en_q),
            .mag_o(corr_mag[i]),
            .c0_o(corr_c0[i]),
            .c1_o(corr_c1[i]),
            .valid_o(corr_valid[i])
        );

        pss_peak_detector u_peak (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .mag_i(corr_mag[i]),
            .valid_i(corr_valid[i]),
            .peak_o(peak[i])
        );
    end

    // the half-sums can move on while the peak is being judged, so keep
    // the values that were valid alongside the magnitude
    acc_t c0_d_q [3];
    acc_t c1_d_q [3];

    always_ff @(posedge clk_i) begin
        c0_d_q <= corr_c0;
        c1_d_q <= corr_c1;
    end

    // ------------------------------------------------------------------
    // mode FSM
    // ------------------------------------------------------------------
    logic one_hot;
    logic [1:0] hit_idx;
    logic hit;

    always_comb begin
        one_hot = (peak == 3'b001) || (peak == 3'b010) || (peak == 3'b100);
        hit_idx = peak[2] ? 2'd2 : (peak[1] ? 2'd1 : 2'd0);
        case (mode_i)
            MODE_SEARCH: hit = one_hot;
            // an out of range request never matches, so find stays quiet
            MODE_FIND:   hit = one_hot && (requested_n_id_2_i == hit_idx);
            default:     hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            corr_en_q <= 1'b0;
            n_id_2_valid_o <= 1'b0;
            n_id_2_o <= '0;
        end else begin
            corr_en_q <= (mode_i != MODE_PAUSE);
            n_id_2_valid_o <= hit;
            if (hit) begin
                n_id_2_o <= hit_idx;
            end
        end
    end

    // ------------------------------------------------------------------
    // offset FSM
    // ------------------------------------------------------------------
    // once a peak is taken, later peaks are ignored until the result is out
    cfo_state_t cfo_state_q;
    acc_t cfo_c0_q;
    acc_t cfo_c1_q;
    logic cfo_start_q;
    logic signed [`PSS_PROD_DW-1:0] prod_re;
    logic signed [`PSS_PROD_DW-1:0] prod_im;
    logic calc_done;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cfo_state_q <= CFO_WAIT_PEAK;
            cfo_start_q <= 1'b0;
            cfo_valid_o <= 1'b0;
        end else begin
            cfo_start_q <= 1'b0;
            cfo_valid_o <= 1'b0;
            case (cfo_state_q)
                CFO_WAIT_PEAK: begin
                    if (hit) begin
                        cfo_state_q <= CFO_LAUNCH;
                    end
                end
                CFO_LAUNCH: begin
                    cfo_start_q <= 1'b1;
                    cfo_state_q <= CFO_WAIT_RESULT;
                end
                CFO_WAIT_RESULT: begin
                    if (calc_done) begin
                        cfo_valid_o <= 1'b1;
                        cfo_state_q <= CFO_WAIT_PEAK;
                    end
                end
                default: cfo_state_q <= CFO_WAIT_PEAK;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cfo_state_q == CFO_WAIT_PEAK && hit) begin
            cfo_c0_q <= c0_d_q[hit_idx];
            cfo_c1_q <= c1_d_q[hit_idx];
        end
        if (cfo_state_q == CFO_WAIT_RESULT && calc_done) begin
            cfo_re_o <= prod_re;
            cfo_im_o <= prod_im;
        end
    end

    pss_cfo_calc u_cfo (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .c0_i(cfo_c0_q),
        .c1_i(cfo_c1_q),
        .start_i(cfo_start_q),
        .cfo_re_o(prod_re),
        .cfo_im_o(prod_im),
        .done_o(calc_done)
    );

    // a reported N_id_2 came from a single peak, on the reported branch
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_2_valid_o |-> $past(peak) == (3'b001 << n_id_2_o));

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        cfo_valid_o |=> !cfo_valid_o);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 20ns
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* bench/tb_pss_detector.sv */
`timescale 1ns/1ps
`include "pss_cfg.svh"

module tb_pss_detector import pss_pkg::*; ();

    // each sample takes at most two cycles, plus flush gaps and mode changes
    localparam int STIM_SAMPLES = 530;
    localparam int STIM_CYCLES = 2 * STIM_SAMPLES + 6 * 14 + 4;
    localparam int MAX_CYCLES = STIM_CYCLES + 64;
    localparam int HALF = `PSS_LEN / 2;
    localparam int WIN = `PSS_WINDOW_LEN;

    logic clk_i;
    logic reset_ni;
    sample_t sample_i;
    logic sample_valid_i;
    mode_t mode_i;
    logic [1:0] requested_n_id_2_i;
    logic [1:0] n_id_2_o;
    logic n_id_2_valid_o;
    logic signed [`PSS_PROD_DW-1:0] cfo_re_o;
    logic signed [`PSS_PROD_DW-1:0] cfo_im_o;
    logic cfo_valid_o;

    tb_clock u_clk (.clk_o(clk_i));

    pss_detector DUT (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sample_i(sample_i),
        .sample_valid_i(sample_valid_i),
        .mode_i(mode_i),
        .requested_n_id_2_i(requested_n_id_2_i),
        .n_id_2_o(n_id_2_o),
        .n_id_2_valid_o(n_id_2_valid_o),
        .cfo_re_o(cfo_re_o),
        .cfo_im_o(cfo_im_o),
        .cfo_valid_o(cfo_valid_o)
    );

    logic [31:0] lfsr_q = 32'hb170;
    int n_checks = 0;
    int n_errors = 0;
    int test_idx = 0;
    int test_err0;
    int nid_events;
    int cfo_events;
    int cycles = 0;

    // ----------------------------------------------------------------------
    // random numbers and compare tasks
    // ----------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input longint got, input longint exp);
        n_errors++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_mag(input string name, input mag_t got, input mag_t exp);
        n_checks++;
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        n_checks++;
        if (got.re !== exp.re) report_mismatch({name, ".re"}, got.re, exp.re);
        if (got.im !== exp.im) report_mismatch({name, ".im"}, got.im, exp.im);
    endtask

    task automatic check_nid_event(input logic gv, input logic [1:0] gid,
                                   input logic ev, input logic [1:0] eid);
        n_checks++;
        if (gv !== ev) begin
            report_mismatch("n_id_2_valid_o", gv, ev);
        end else if (ev && gid !== eid) begin
            report_mismatch("n_id_2_o", gid, eid);
        end
    endtask

    task automatic check_cfo_result(input logic gv,
                                    input logic signed [`PSS_PROD_DW-1:0] gre,
                                    input logic signed [`PSS_PROD_DW-1:0] gim,
                                    input logic ev,
                                    input logic signed [`PSS_PROD_DW-1:0] ere,
                                    input logic signed [`PSS_PROD_DW-1:0] eim);
        n_checks++;
        if (gv !== ev) begin
            report_mismatch("cfo_valid_o", gv, ev);
        end else if (ev) begin
            if (gre !== ere) report_mismatch("cfo_re_o", gre, ere);
            if (gim !== eim) report_mismatch("cfo_im_o", gim, eim);
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model, one step per rising edge on the pre-edge values
    // ----------------------------------------------------------------------
    sample_t m_dl [`PSS_LEN];
    acc_t m_s1c0 [3];
    acc_t m_s1c1 [3];
    acc_t m_c0 [3];
    acc_t m_c1 [3];
    acc_t m_c0d [3];
    acc_t m_c1d [3];
    mag_t m_mag [3];
    int m_win [3][WIN];
    int m_sum [3];
    int m_fill [3];
    logic [2:0] m_peak;
    logic m_en;
    logic m_s1v;
    logic m_v;
    logic m_nv;
    logic [1:0] m_nid;
    int m_cnt;
    logic m_cv;
    longint pend_re;
    longint pend_im;
    logic signed [`PSS_PROD_DW-1:0] exp_re;
    logic signed [`PSS_PROD_DW-1:0] exp_im;

    always @(posedge clk_i) begin : model
        int npk;
        int idx;
        int tr;
        int ti;
        int sr [2];
        int si [2];
        int fr;
        int fi;
        logic hit;
        logic v;
        if (!reset_ni) begin
            m_en = 0;
            m_s1v = 0;
            m_v = 0;
            m_peak = '0;
            m_nv = 0;
            m_nid = '0;
            m_cnt = 0;
            m_cv = 0;
            // the delay line starts from silence
            for (int k = 0; k < `PSS_LEN; k++) m_dl[k] = '0;
            for (int i = 0; i < 3; i++) begin
                m_sum[i] = 0;
                m_fill[i] = 0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                check_flag($sformatf("corr_valid[%0d]", i), DUT.corr_valid[i], m_v);
                if (m_v) begin
                    check_mag($sformatf("corr_mag[%0d]", i), DUT.corr_mag[i], m_mag[i]);
                    check_acc($sformatf("corr_c0[%0d]", i), DUT.corr_c0[i], m_c0[i]);
                    check_acc($sformatf("corr_c1[%0d]", i), DUT.corr_c1[i], m_c1[i]);
                end
            end
            check_nid_event(n_id_2_valid_o, n_id_2_o, m_nv, m_nid);
            check_cfo_result(cfo_valid_o, cfo_re_o, cfo_im_o, m_cv, exp_re, exp_im);
            if (n_id_2_valid_o === 1'b1) nid_events++;
            if (cfo_valid_o === 1'b1) cfo_events++;

            // exactly one peak, and in find mode it must be the requested one
            npk = m_peak[0] + m_peak[1] + m_peak[2];
            idx = m_peak[2] ? 2 : (m_peak[1] ? 1 : 0);
            hit = (npk == 1) && (mode_i == MODE_SEARCH
                  || (mode_i == MODE_FIND && requested_n_id_2_i == idx));

            m_cv = 0;
            if (m_cnt > 0) begin
                m_cnt--;
                if (m_cnt == 0) begin
                    m_cv = 1;
                    exp_re = pend_re;
                    exp_im = pend_im;
                end
            end else if (hit) begin
                // conj(c0) * c1
                pend_re = longint'(m_c0d[idx].re) * m_c1d[idx].re
                        + longint'(m_c0d[idx].im) * m_c1d[idx].im;
                pend_im = longint'(m_c0d[idx].re) * m_c1d[idx].im
                        - longint'(m_c0d[idx].im) * m_c1d[idx].re;
                m_cnt = 4;
            end
            m_nv = hit;
            if (hit) m_nid = idx;

            m_c0d = m_c0;
            m_c1d = m_c1;
            for (int i = 0; i < 3; i++) begin
                m_peak[i] = m_v && m_fill[i] == WIN
                            && m_mag[i] > ((m_sum[i] / WIN) << `PSS_PEAK_SHIFT);
                if (m_v) begin
                    if (m_fill[i] == WIN) begin
                        m_sum[i] = m_sum[i] + m_mag[i] - m_win[i][WIN-1];
                    end else begin
                        m_sum[i] = m_sum[i] + m_mag[i];
                        m_fill[i]++;
                    end
                    for (int k = WIN - 1; k > 0; k--) m_win[i][k] = m_win[i][k-1];
                    m_win[i][0] = m_mag[i];
                end
            end

            if (m_s1v) begin
                for (int i = 0; i < 3; i++) begin
                    m_c0[i] = m_s1c0[i];
                    m_c1[i] = m_s1c1[i];
                    fr = m_s1c0[i].re + m_s1c1[i].re;
                    fi = m_s1c0[i].im + m_s1c1[i].im;
                    m_mag[i] = (fr < 0 ? -fr : fr) + (fi < 0 ? -fi : fi);
                end
            end
            m_v = m_s1v;

            v = sample_valid_i && m_en;
            if (v) begin
                for (int k = 0; k < `PSS_LEN - 1; k++) m_dl[k] = m_dl[k+1];
                m_dl[`PSS_LEN-1] = sample_i;
                for (int i = 0; i < 3; i++) begin
                    sr = '{0, 0};
                    si = '{0, 0};
                    for (int k = 0; k < `PSS_LEN; k++) begin
                        tr = PSS_TAPS[i][k][1] ? -1 : 1;
                        ti = PSS_TAPS[i][k][0] ? -1 : 1;
                        sr[k / HALF] += m_dl[k].re * tr + m_dl[k].im * ti;
                        si[k / HALF] += m_dl[k].im * tr - m_dl[k].re * ti;
                    end
                    m_s1c0[i].re = sr[0];
                    m_s1c0[i].im = si[0];
                    m_s1c1[i].re = sr[1];
                    m_s1c1[i].im = si[1];
                end
            end
            m_s1v = v;
            m_en = (mode_i != MODE_PAUSE);
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic drive(input sample_t s, input logic v);
        @(posedge clk_i);
        sample_i <= s;
        sample_valid_i <= v;
    endtask

    function automatic sample_t noise();
        sample_t s;
        logic signed [2:0] r;
        r = rand_bits(3);
        s.re = r;
        r = rand_bits(3);
        s.im = r;
        return s;
    endfunction

    task automatic send(input sample_t s);
        if (rand_bits(3) == 3'd0) drive(noise(), 1'b0);
        drive(s, 1'b1);
    endtask

    task automatic send_noise(input int n);
        repeat (n) send(noise());
    endtask

    task automatic idle(input int n);
        repeat (n) drive(noise(), 1'b0);
    endtask

    task automatic set_mode(input mode_t m, input logic [1:0] req);
        @(posedge clk_i);
        mode_i <= m;
        requested_n_id_2_i <= req;
        sample_valid_i <= 1'b0;
    endtask

    // tap value of one sequence scaled by amp, zero outside the sequence
    function automatic sample_t tap_sample(input int seq, input int k, input int amp);
        sample_t s;
        s = '0;
        if (k >= 0 && k < `PSS_LEN) begin
            s.re = PSS_TAPS[seq][k][1] ? -amp : amp;
            s.im = PSS_TAPS[seq][k][0] ? -amp : amp;
        end
        return s;
    endfunction

    // the second half turns by quarter steps, a half turn would cancel the sum
    task automatic send_burst(input int seq);
        sample_t s;
        sample_t t;
        int rot;
        rot = rand_bits(2);
        if (rot == 2) rot = 3;
        for (int k = 0; k < `PSS_LEN; k++) begin
            s = tap_sample(seq, k, 32);
            if (k >= HALF) begin
                repeat (rot) begin
                    t = s;
                    s.re = -t.im;
                    s.im = t.re;
                end
            end
            send(s);
        end
        send_noise(24);
    endtask

    // two sequences on top of each other, the second one a few samples later
    task automatic send_overlap(input int seq_a, input int seq_b, input int lag);
        sample_t a;
        sample_t b;
        sample_t s;
        for (int k = 0; k < `PSS_LEN + lag; k++) begin
            a = tap_sample(seq_a, k, 16);
            b = tap_sample(seq_b, k - lag, 16);
            s.re = a.re + b.re;
            s.im = a.im + b.im;
            send(s);
        end
        send_noise(24);
    endtask

    task automatic begin_test();
        test_idx++;
        test_err0 = n_errors;
        nid_events = 0;
        cfo_events = 0;
    endtask

    task automatic end_test(input string name);
        idle(12);
        $display("test %0d %s: %0d n_id_2 events, %0d offset results, %0d errors",
                 test_idx, name, nid_events, cfo_events, n_errors - test_err0);
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset_ni = 1'b0;
        sample_i = '0;
        sample_valid_i = 1'b0;
        mode_i = MODE_SEARCH;
        requested_n_id_2_i = 2'd0;
        repeat (2) @(posedge clk_i);
        reset_ni <= 1'b1;

        begin_test();
        send_noise(40);
        end_test("quiet after reset");

        begin_test();
        for (int s = 0; s < 3; s++) send_burst(s);
        end_test("search");

        begin_test();
        set_mode(MODE_FIND, 2'd1);
        send_burst(0);
        send_burst(2);
        send_burst(1);
        end_test("find");

        begin_test();
        set_mode(MODE_PAUSE, 2'd0);
        send_burst(0);
        send_burst(1);
        set_mode(MODE_SEARCH, 2'd0);
        send_noise(40);
        send_burst(2);
        end_test("pause and resume");

        begin_test();
        send_overlap(0, 1, 3);
        send_overlap(2, 0, 2);
        end_test("offset lock-out");

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/pss_pkg.sv
hdl/pss_correlator.sv
hdl/pss_peak_detector.sv
hdl/pss_cfo_calc.sv
hdl/pss_detector.sv
bench/tb_clock.sv
bench/tb_pss_detector.sv

/* Bender.yml */
package:
  name: pss_detector

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pss_pkg.sv
      - hdl/pss_correlator.sv
      - hdl/pss_peak_detector.sv
      - hdl/pss_cfo_calc.sv
      - hdl/pss_detector.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_clock.sv
      - bench/tb_pss_detector.sv
